// File: Bender.yml
package:
  name: exu

sources:
  - include_dirs:
      - src
    files:
      - src/exu_pkg.sv
      - src/exu_if.sv
      - src/dispatch_decode.sv
      - src/exers.sv
      - src/scalu.sv
      - src/mcalu.sv
      - src/wb_result.sv
      - src/exu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/exu_clkgen.sv
      - tb/exu_props.sv
      - tb/exu_tb.sv

// File: files.f
+incdir+src
src/exu_pkg.sv
src/exu_if.sv
src/dispatch_decode.sv
src/exers.sv
src/scalu.sv
src/mcalu.sv
src/wb_result.sv
src/exu_top.sv
tb/exu_clkgen.sv
tb/exu_props.sv
tb/exu_tb.sv

// File: src/dispatch_decode.sv
// Dispatch front end that runs the four-phase input handshake and feeds one op to the station
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module dispatch_decode (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush,
  input  logic            in_req,
  input  exu_pkg::op_t    in_op,
  input  exu_pkg::robid_t in_robid,
  input  exu_pkg::rd_t    in_rd,
  input  logic            in_op1ready,
  input  exu_pkg::word_t  in_op1,
  input  logic            in_op2ready,
  input  exu_pkg::word_t  in_op2,
  output logic            in_ack,
  dispatch_if.dec         disp,
  wb_if.snoop             wb
);

  exu_pkg::dec_state_t state_q;
  exu_pkg::op_t        op_q;
  exu_pkg::robid_t     robid_q;
  exu_pkg::rd_t        rd_q;
  logic                op1rdy_q;
  logic                op2rdy_q;
  exu_pkg::word_t      op1_q;
  exu_pkg::word_t      op2_q;
  exu_pkg::op_t        in_op_norm;
  logic                wb_wake;
  logic                in_hit1;
  logic                in_hit2;
  logic                hold_hit1;
  logic                hold_hit2;

  // Writebacks with rd bit 5 set wake nothing
  assign wb_wake = wb.valid & ~wb.rd[5];

  // Tag matches on the incoming fields and on the held copy
  assign in_hit1   = wb_wake & ~in_op1ready & (in_op1[6:0] == wb.robid);
  assign in_hit2   = wb_wake & ~in_op2ready & (in_op2[6:0] == wb.robid);
  assign hold_hit1 = wb_wake & ~op1rdy_q & (op1_q[6:0] == wb.robid);
  assign hold_hit2 = wb_wake & ~op2rdy_q & (op2_q[6:0] == wb.robid);

  // Unknown multiply-group codes fold onto MUL
  assign in_op_norm = (`EXU_IS_MUL(in_op) && in_op != `OP_MULH) ? `OP_MUL : in_op;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= exu_pkg::DEC_IDLE;
    end else begin
      case (state_q)
        exu_pkg::DEC_IDLE: begin
          // A request seen during flush is acknowledged but never written
          if (in_req) state_q <= flush ? exu_pkg::DEC_ACK : exu_pkg::DEC_WRITE;
        end
        exu_pkg::DEC_WRITE: begin
          if (flush || !disp.stall) state_q <= exu_pkg::DEC_ACK;
        end
        exu_pkg::DEC_ACK: begin
          if (!in_req) state_q <= exu_pkg::DEC_IDLE;
        end
        default: state_q <= exu_pkg::DEC_IDLE;
      endcase
    end
  end

  // Field capture, then keep tracking wakeups while waiting on the station
  always_ff @(posedge clk) begin
    if (state_q == exu_pkg::DEC_IDLE && in_req) begin
      op_q     <= in_op_norm;
      robid_q  <= in_robid;
      rd_q     <= in_rd;
      op1rdy_q <= in_op1ready | in_hit1;
      op1_q    <= in_hit1 ? wb.result : in_op1;
      op2rdy_q <= in_op2ready | in_hit2;
      op2_q    <= in_hit2 ? wb.result : in_op2;
    end else if (state_q == exu_pkg::DEC_WRITE) begin
      op1rdy_q <= disp.op1ready;
      op1_q    <= disp.op1;
      op2rdy_q <= disp.op2ready;
      op2_q    <= disp.op2;
    end
  end

  assign in_ack = (state_q == exu_pkg::DEC_ACK);

  // Same-cycle wakeup is folded into what the station sees
  assign disp.write    = (state_q == exu_pkg::DEC_WRITE) & ~flush;
  assign disp.op       = op_q;
  assign disp.robid    = robid_q;
  assign disp.rd       = rd_q;
  assign disp.op1ready = op1rdy_q | hold_hit1;
  assign disp.op1      = hold_hit1 ? wb.result : op1_q;
  assign disp.op2ready = op2rdy_q | hold_hit2;
  assign disp.op2      = hold_hit2 ? wb.result : op2_q;

endmodule

`default_nettype wire

// File: src/exers.sv
// Reservation station that holds dispatched ops until operands resolve and issues them per unit
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module exers #(
  parameter int RS_ENTRIES = `EXU_RS_ENTRIES
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   flush,
  dispatch_if.rs disp,
  issue_if.rs    sc,
  issue_if.rs    mc,
  wb_if.snoop    wb
);

  // Entry state
  logic [RS_ENTRIES-1:0] valid_q;
  logic [RS_ENTRIES-1:0] op1rdy_q;
  logic [RS_ENTRIES-1:0] op2rdy_q;
  exu_pkg::op_t          op_q    [RS_ENTRIES];
  exu_pkg::robid_t       robid_q [RS_ENTRIES];
  exu_pkg::rd_t          rd_q    [RS_ENTRIES];
  exu_pkg::word_t        op1_q   [RS_ENTRIES];
  exu_pkg::word_t        op2_q   [RS_ENTRIES];

  logic                  wb_wake;
  logic                  full;
  logic                  accept;
  logic [RS_ENTRIES-1:0] hit1;
  logic [RS_ENTRIES-1:0] hit2;
  logic [RS_ENTRIES-1:0] is_mul;
  logic [RS_ENTRIES-1:0] ready;
  logic [RS_ENTRIES-1:0] ins_oh;
  logic [RS_ENTRIES-1:0] sc_oh;
  logic [RS_ENTRIES-1:0] mc_oh;
  logic [RS_ENTRIES-1:0] clr_vec;

  // Isolates the lowest set bit
  function automatic logic [RS_ENTRIES-1:0] lowest_one(input logic [RS_ENTRIES-1:0] v);
    return v & (~v + 1'b1);
  endfunction

  assign wb_wake = wb.valid & ~wb.rd[5];

  // Associative tag compare against every waiting operand
  always_comb begin
    for (int i = 0; i < RS_ENTRIES; i++) begin
      hit1[i]   = wb_wake & valid_q[i] & ~op1rdy_q[i] & (op1_q[i][6:0] == wb.robid);
      hit2[i]   = wb_wake & valid_q[i] & ~op2rdy_q[i] & (op2_q[i][6:0] == wb.robid);
      is_mul[i] = `EXU_IS_MUL(op_q[i]);
    end
  end

  assign ready = valid_q & op1rdy_q & op2rdy_q;

  // Insert into the lowest free slot
  assign full        = &valid_q;
  assign disp.stall  = full;
  assign accept      = disp.write & ~full & ~flush;
  assign ins_oh      = accept ? lowest_one(~valid_q) : '0;

  // Separate pick per op group, lowest index first
  assign sc_oh    = lowest_one(ready & ~is_mul);
  assign mc_oh    = lowest_one(ready & is_mul);
  assign sc.issue = (|sc_oh) & ~sc.stall;
  assign mc.issue = (|mc_oh) & ~mc.stall;
  assign clr_vec  = (sc.issue ? sc_oh : '0) | (mc.issue ? mc_oh : '0);

  // One-hot select onto both issue buses
  always_comb begin
    sc.op    = '0;
    sc.robid = '0;
    sc.rd    = '0;
    sc.op1   = '0;
    sc.op2   = '0;
    mc.op    = '0;
    mc.robid = '0;
    mc.rd    = '0;
    mc.op1   = '0;
    mc.op2   = '0;
    for (int i = 0; i < RS_ENTRIES; i++) begin
      if (sc_oh[i]) begin
        sc.op    = op_q[i];
        sc.robid = robid_q[i];
        sc.rd    = rd_q[i];
        sc.op1   = op1_q[i];
        sc.op2   = op2_q[i];
      end
      if (mc_oh[i]) begin
        mc.op    = op_q[i];
        mc.robid = robid_q[i];
        mc.rd    = rd_q[i];
        mc.op1   = op1_q[i];
        mc.op2   = op2_q[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      valid_q <= '0;
    end else begin
      valid_q <= (valid_q & ~clr_vec) | ins_oh;
    end
  end

  // Payload and operand resolution
  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_ENTRIES; i++) begin
      if (ins_oh[i]) begin
        op_q[i]     <= disp.op;
        robid_q[i]  <= disp.robid;
        rd_q[i]     <= disp.rd;
        op1rdy_q[i] <= disp.op1ready;
        op1_q[i]    <= disp.op1;
        op2rdy_q[i] <= disp.op2ready;
        op2_q[i]    <= disp.op2;
      end else begin
        if (hit1[i]) begin
          op1rdy_q[i] <= 1'b1;
          op1_q[i]    <= wb.result;
        end
        if (hit2[i]) begin
          op2rdy_q[i] <= 1'b1;
          op2_q[i]    <= wb.result;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/exu_defs.svh
// Station depth, multiplier latency and opcode encodings shared by the cluster RTL and testbench
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// Sizes
`define EXU_RS_ENTRIES 8
`define EXU_MUL_CYCLES 4

// Single-cycle group
`define OP_ADD  5'd0
`define OP_SUB  5'd1
`define OP_AND  5'd2
`define OP_OR   5'd3
`define OP_XOR  5'd4
`define OP_SLL  5'd5
`define OP_SRL  5'd6
`define OP_SLT  5'd7

// Multiply group
`define OP_MUL  5'd24
`define OP_MULH 5'd25

// Multiply group is every code with both top bits set
`define EXU_IS_MUL(op) (&(op[4:3]))

`endif

// File: src/exu_if.sv
// Dispatch, issue and writeback bundles that connect the blocks inside the execute cluster
`timescale 1ns/1ps
`default_nettype none

interface dispatch_if;
  logic            write;
  exu_pkg::op_t    op;
  exu_pkg::robid_t robid;
  exu_pkg::rd_t    rd;
  logic            op1ready;
  exu_pkg::word_t  op1;
  logic            op2ready;
  exu_pkg::word_t  op2;
  logic            stall;

  modport dec (output write, op, robid, rd, op1ready, op1, op2ready, op2, input stall);
  modport rs (input write, op, robid, rd, op1ready, op1, op2ready, op2, output stall);
endinterface

// One instance per execution unit
interface issue_if;
  logic            issue;
  exu_pkg::op_t    op;
  exu_pkg::robid_t robid;
  exu_pkg::rd_t    rd;
  exu_pkg::word_t  op1;
  exu_pkg::word_t  op2;
  logic            stall;

  modport rs (output issue, op, robid, rd, op1, op2, input stall);
  modport unit (input issue, op, robid, rd, op1, op2, output stall);
endinterface

interface wb_if;
  logic            valid;
  exu_pkg::robid_t robid;
  exu_pkg::rd_t    rd;
  exu_pkg::word_t  result;

  modport src (output valid, robid, rd, result);
  modport snoop (input valid, robid, rd, result);
endinterface

`default_nettype wire

// File: src/exu_pkg.sv
// Shared vector types and FSM encodings used across the execute cluster, referenced by scoped name
`default_nettype none

package exu_pkg;

  // Operand or result word
  typedef logic [31:0] word_t;

  // ROB tag, also the low bits of a not-ready operand
  typedef logic [6:0] robid_t;

  // Destination register, bit 5 marks no register write
  typedef logic [5:0] rd_t;

  // Opcode
  typedef logic [4:0] op_t;

  // Dispatch handshake states
  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_WRITE,
    DEC_ACK
  } dec_state_t;

endpackage

`default_nettype wire

// File: src/exu_top.sv
// Execute cluster top that wires dispatch, station, units and writeback to plain ports
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module exu_top (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush,
  input  logic            in_req,
  input  exu_pkg::op_t    in_op,
  input  exu_pkg::robid_t in_robid,
  input  exu_pkg::rd_t    in_rd,
  input  logic            in_op1ready,
  input  exu_pkg::word_t  in_op1,
  input  logic            in_op2ready,
  input  exu_pkg::word_t  in_op2,
  output logic            in_ack,
  output logic            out_valid,
  output exu_pkg::robid_t out_robid,
  output exu_pkg::rd_t    out_rd,
  output exu_pkg::word_t  out_result
);

  logic sc_taken;
  logic mc_taken;

  dispatch_if disp ();
  issue_if    sc_iss ();
  issue_if    mc_iss ();
  wb_if       sc_res ();
  wb_if       mc_res ();
  wb_if       bcast ();

  dispatch_decode i_dispatch_decode (
    .clk, .rst_n, .flush, .in_req, .in_op, .in_robid, .in_rd,
    .in_op1ready, .in_op1, .in_op2ready, .in_op2, .in_ack,
    .disp (disp.dec),
    .wb   (bcast.snoop)
  );

  exers #(.RS_ENTRIES(`EXU_RS_ENTRIES)) i_exers (
    .clk, .rst_n, .flush,
    .disp (disp.rs),
    .sc   (sc_iss.rs),
    .mc   (mc_iss.rs),
    .wb   (bcast.snoop)
  );

  scalu i_scalu (
    .clk, .rst_n, .flush,
    .iss       (sc_iss.unit),
    .res       (sc_res.src),
    .res_taken (sc_taken)
  );

  mcalu i_mcalu (
    .clk, .rst_n, .flush,
    .iss       (mc_iss.unit),
    .res       (mc_res.src),
    .res_taken (mc_taken)
  );

  wb_result i_wb_result (
    .clk, .rst_n, .flush,
    .sc       (sc_res.snoop),
    .mc       (mc_res.snoop),
    .sc_taken (sc_taken),
    .mc_taken (mc_taken),
    .bcast    (bcast.src)
  );

  // Broadcast doubles as the cluster output
  assign out_valid  = bcast.valid;
  assign out_robid  = bcast.robid;
  assign out_rd     = bcast.rd;
  assign out_result = bcast.result;

endmodule

`default_nettype wire

// File: src/mcalu.sv
// Iterative unsigned multiplier that stalls issue while busy and until its result is taken
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module mcalu (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  flush,
  issue_if.unit iss,
  wb_if.src     res,
  input  logic  res_taken
);

  // Multiplier bits consumed per cycle
  localparam int STEP = 32 / `EXU_MUL_CYCLES;
  localparam int CW   = $clog2(`EXU_MUL_CYCLES);
  localparam int LAST = `EXU_MUL_CYCLES - 1;

  logic            busy_q;
  logic            done_q;
  logic [CW-1:0]   step_q;
  logic [63:0]     acc_q;
  logic [63:0]     a_sh_q;
  exu_pkg::word_t  b_sh_q;
  logic            high_q;
  exu_pkg::robid_t robid_q;
  exu_pkg::rd_t    rd_q;

  assign iss.stall = busy_q | (done_q & ~res_taken);

  // Step 0 happens on the issue edge, the rest while busy
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      step_q <= '0;
    end else if (iss.issue) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
      step_q <= CW'(1);
    end else if (busy_q) begin
      if (step_q == CW'(LAST)) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
      step_q <= step_q + 1'b1;
    end else if (done_q && res_taken) begin
      done_q <= 1'b0;
    end
  end

  // Shift-add over STEP-bit slices of op2
  always_ff @(posedge clk) begin
    if (iss.issue) begin
      acc_q   <= 64'(iss.op1) * 64'(iss.op2[STEP-1:0]);
      a_sh_q  <= {32'b0, iss.op1} << STEP;
      b_sh_q  <= iss.op2 >> STEP;
      high_q  <= (iss.op == `OP_MULH);
      robid_q <= iss.robid;
      rd_q    <= iss.rd;
    end else if (busy_q) begin
      acc_q  <= acc_q + a_sh_q * 64'(b_sh_q[STEP-1:0]);
      a_sh_q <= a_sh_q << STEP;
      b_sh_q <= b_sh_q >> STEP;
    end
  end

  assign res.valid  = done_q;
  assign res.robid  = robid_q;
  assign res.rd     = rd_q;
  assign res.result = high_q ? acc_q[63:32] : acc_q[31:0];

endmodule

`default_nettype wire

// File: src/scalu.sv
// Single-cycle ALU that registers its result and holds it until the writeback arbiter takes it
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module scalu (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  flush,
  issue_if.unit iss,
  wb_if.src     res,
  input  logic  res_taken
);

  logic            pend_q;
  exu_pkg::robid_t robid_q;
  exu_pkg::rd_t    rd_q;
  exu_pkg::word_t  result_q;
  exu_pkg::word_t  alu_res;

  always_comb begin
    case (iss.op)
      `OP_ADD: alu_res = iss.op1 + iss.op2;
      `OP_SUB: alu_res = iss.op1 - iss.op2;
      `OP_AND: alu_res = iss.op1 & iss.op2;
      `OP_OR:  alu_res = iss.op1 | iss.op2;
      `OP_XOR: alu_res = iss.op1 ^ iss.op2;
      `OP_SLL: alu_res = iss.op1 << iss.op2[4:0];
      `OP_SRL: alu_res = iss.op1 >> iss.op2[4:0];
      `OP_SLT: alu_res = {31'b0, $signed(iss.op1) < $signed(iss.op2)};
      default: alu_res = iss.op1 + iss.op2;
    endcase
  end

  // Free again in the cycle the arbiter takes the result
  assign iss.stall = pend_q & ~res_taken;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      pend_q <= 1'b0;
    end else if (iss.issue) begin
      pend_q <= 1'b1;
    end else if (res_taken) begin
      pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (iss.issue) begin
      robid_q  <= iss.robid;
      rd_q     <= iss.rd;
      result_q <= alu_res;
    end
  end

  assign res.valid  = pend_q;
  assign res.robid  = robid_q;
  assign res.rd     = rd_q;
  assign res.result = result_q;

endmodule

`default_nettype wire

// File: src/wb_result.sv
// Writeback arbiter that picks one unit result per cycle and registers it as the broadcast
`timescale 1ns/1ps
`default_nettype none

module wb_result (
  input  logic clk,
  input  logic rst_n,
  input  logic flush,
  wb_if.snoop  sc,
  wb_if.snoop  mc,
  output logic sc_taken,
  output logic mc_taken,
  wb_if.src    bcast
);

  logic            valid_q;
  exu_pkg::robid_t robid_q;
  exu_pkg::rd_t    rd_q;
  exu_pkg::word_t  result_q;

  // Multiplier first, the ALU keeps its result otherwise
  assign mc_taken = mc.valid;
  assign sc_taken = sc.valid & ~mc.valid;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= sc.valid | mc.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (mc.valid) begin
      robid_q  <= mc.robid;
      rd_q     <= mc.rd;
      result_q <= mc.result;
    end else if (sc.valid) begin
      robid_q  <= sc.robid;
      rd_q     <= sc.rd;
      result_q <= sc.result;
    end
  end

  assign bcast.valid  = valid_q;
  assign bcast.robid  = robid_q;
  assign bcast.rd     = rd_q;
  assign bcast.result = result_q;

endmodule

`default_nettype wire

// File: tb/exu_clkgen.sv
// Clock and reset source for the execute cluster testbench, instantiated once by the testbench top
`timescale 1ns/1ps
`default_nettype none

module exu_clkgen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_NS    = 20;
  localparam int RST_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #HALF_NS clk = ~clk;
  end

  // Release lands just after a rising edge, like every other input
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb/exu_props.sv
// Handshake, issue and insert assertions for the execute cluster, bound into decode and station
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module exu_props #(
  parameter int N = `EXU_RS_ENTRIES
) (
  input logic         clk,
  input logic         rst_n,
  input logic         flush,
  input logic         in_req,
  input logic         in_ack,
  input logic [N-1:0] valid,
  input logic [N-1:0] sc_pick,
  input logic         sc_stall,
  input logic [N-1:0] mc_pick,
  input logic         mc_stall,
  input logic         rs_full
);

  int unsigned fail_count = 0;

  // Acknowledge only answers a held request
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(in_ack) |-> $past(in_req))
    else begin
      fail_count++;
      $error("in_ack rose while in_req was low");
    end

  // A stalled unit leaves its candidate entry in the station
  sc_no_issue_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    (sc_stall && !flush) |=> ((valid & $past(sc_pick)) == $past(sc_pick)))
    else begin
      fail_count++;
      $error("ALU entry left the station while the ALU stalls");
    end

  mc_no_issue_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    (mc_stall && !flush) |=> ((valid & $past(mc_pick)) == $past(mc_pick)))
    else begin
      fail_count++;
      $error("multiplier entry left the station while the multiplier stalls");
    end

  // A full station takes nothing
  no_insert_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    (rs_full && !flush) |=> ((valid & ~$past(valid)) == '0))
    else begin
      fail_count++;
      $error("station insert while all entries are valid");
    end

endmodule

bind dispatch_decode exu_props i_dec_props (
  .clk (clk), .rst_n (rst_n), .flush (flush), .in_req (in_req), .in_ack (in_ack),
  .valid ('0), .sc_pick ('0), .sc_stall (1'b0), .mc_pick ('0), .mc_stall (1'b0),
  .rs_full (1'b0)
);

bind exers exu_props #(.N(RS_ENTRIES)) i_rs_props (
  .clk (clk), .rst_n (rst_n), .flush (flush), .in_req (1'b0), .in_ack (1'b0),
  .valid (valid_q), .sc_pick (sc_oh), .sc_stall (sc.stall), .mc_pick (mc_oh),
  .mc_stall (mc.stall), .rs_full (full)
);

`default_nettype wire

// File: tb/exu_tb.sv
// Table-driven testbench for the execute cluster; run as top with the sources from files.f
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module exu_tb;

  localparam int NROWS        = 34;
  localparam int RST_CYCLES   = 16;
  localparam int CLK_NS       = 40;
  localparam int BLOCK_CYCLES = 20;

  // Row modes: fixed values, random ready values, dispatch into a full station
  localparam logic [1:0] M_FIX = 2'd0;
  localparam logic [1:0] M_RND = 2'd1;
  localparam logic [1:0] M_BLK = 2'd2;
  localparam logic       RDY   = 1'b1;
  localparam logic       TAG   = 1'b0;

  // Tag that no row ever produces
  localparam exu_pkg::word_t NO_TAG = 32'd127;

  typedef struct packed {
    exu_pkg::op_t    op;
    exu_pkg::robid_t robid;
    exu_pkg::rd_t    rd;
    logic            r1;
    exu_pkg::word_t  v1;
    logic            r2;
    exu_pkg::word_t  v2;
    logic [1:0]      mode;
  } row_t;

  logic            clk;
  logic            rst_n;
  logic            flush;
  logic            in_req;
  exu_pkg::op_t    in_op;
  exu_pkg::robid_t in_robid;
  exu_pkg::rd_t    in_rd;
  logic            in_op1ready;
  exu_pkg::word_t  in_op1;
  logic            in_op2ready;
  exu_pkg::word_t  in_op2;
  logic            in_ack;
  logic            out_valid;
  exu_pkg::robid_t out_robid;
  exu_pkg::rd_t    out_rd;
  exu_pkg::word_t  out_result;

  row_t           rows [NROWS];
  int             nrows;
  int             errors;
  int             expect_count;
  int             seen_count;
  int             prop_fails;
  integer         seed;

  // Model state per robid, written as each row is dispatched
  exu_pkg::word_t exp_val  [128];
  exu_pkg::rd_t   exp_rd   [128];
  logic           known    [128];
  logic           will_ret [128];
  logic           seen     [128];

  exu_clkgen i_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  exu_top i_exu_top (
    .clk, .rst_n, .flush, .in_req, .in_op, .in_robid, .in_rd,
    .in_op1ready, .in_op1, .in_op2ready, .in_op2, .in_ack,
    .out_valid, .out_robid, .out_rd, .out_result
  );

  task automatic compare(input logic [31:0] got, input logic [31:0] want, input string what);
    if (got !== want) begin
      errors++;
      $display("ERR %0t ns: %s got %0h expected %0h", $time, what, got, want);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Expected result straight from the ALU and multiplier rules
  function automatic exu_pkg::word_t ref_alu(input exu_pkg::op_t op, input exu_pkg::word_t a,
                                             input exu_pkg::word_t b);
    logic [63:0] prod;
    prod = {32'b0, a} * {32'b0, b};
    if (op[4] && op[3]) begin
      return (op == `OP_MULH) ? prod[63:32] : prod[31:0];
    end
    case (op)
      `OP_SUB: return a - b;
      `OP_AND: return a & b;
      `OP_OR:  return a | b;
      `OP_XOR: return a ^ b;
      `OP_SLL: return a << b[4:0];
      `OP_SRL: return a >> b[4:0];
      `OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return a + b;
    endcase
  endfunction

  task automatic put(input exu_pkg::op_t op, input exu_pkg::robid_t id, input exu_pkg::rd_t rd,
                     input logic r1, input exu_pkg::word_t v1, input logic r2,
                     input exu_pkg::word_t v2, input logic [1:0] mode);
    rows[nrows] = {op, id, rd, r1, v1, r2, v2, mode};
    nrows++;
  endtask

  task automatic build_table();
    // Independent single-cycle ops
    put(`OP_ADD, 7'd1, 6'd1, RDY, 32'd10, RDY, 32'd20, M_FIX);
    put(`OP_SUB, 7'd2, 6'd2, RDY, 32'd0, RDY, 32'd0, M_RND);
    put(`OP_AND, 7'd3, 6'd3, RDY, 32'd0, RDY, 32'd0, M_RND);
    put(`OP_OR,  7'd4, 6'd4, RDY, 32'd0, RDY, 32'd0, M_RND);
    put(`OP_XOR, 7'd5, 6'd5, RDY, 32'd0, RDY, 32'd0, M_RND);
    put(`OP_SLL, 7'd6, 6'd6, RDY, 32'h0000_00f1, RDY, 32'd35, M_FIX);
    put(`OP_SRL, 7'd7, 6'd7, RDY, 32'h8000_0000, RDY, 32'd4, M_FIX);
    put(`OP_SLT, 7'd8, 6'd8, RDY, 32'hffff_fffe, RDY, 32'd1, M_FIX);
    put(`OP_SLT, 7'd9, 6'd9, RDY, 32'd0, RDY, 32'd0, M_RND);
    // Chains, the slow multiply wakes a waiting entry, the ALU one lands in dispatch
    put(`OP_MUL, 7'd10, 6'd10, RDY, 32'd1000, RDY, 32'd3000, M_FIX);
    put(`OP_ADD, 7'd11, 6'd11, TAG, 32'd10, RDY, 32'd5, M_FIX);
    put(`OP_SUB, 7'd12, 6'd12, TAG, 32'd11, TAG, 32'd10, M_FIX);
    put(`OP_ADD, 7'd13, 6'd13, RDY, 32'd0, RDY, 32'd0, M_RND);
    put(`OP_XOR, 7'd14, 6'd14, TAG, 32'd13, RDY, 32'h0000_ffff, M_FIX);
    // No register write, so its dependent waits until the flush
    put(`OP_OR,  7'd15, 6'h20, RDY, 32'd0, RDY, 32'd0, M_RND);
    put(`OP_ADD, 7'd16, 6'd16, TAG, 32'd15, RDY, 32'd1, M_FIX);
    // Multiplies mixed with ALU ops
    put(`OP_MUL,  7'd17, 6'd17, RDY, 32'd0, RDY, 32'd0, M_RND);
    put(`OP_MULH, 7'd18, 6'd18, RDY, 32'd0, RDY, 32'd0, M_RND);
    put(`OP_ADD,  7'd19, 6'd19, RDY, 32'd0, RDY, 32'd0, M_RND);
    put(`OP_MULH, 7'd20, 6'd20, RDY, 32'hffff_ffff, RDY, 32'hffff_ffff, M_FIX);
    put(5'd26,    7'd21, 6'd21, RDY, 32'd0, RDY, 32'd0, M_RND);
    put(`OP_SUB,  7'd22, 6'd22, RDY, 32'd0, RDY, 32'd0, M_RND);
    put(`OP_MUL,  7'd23, 6'd23, TAG, 32'd20, RDY, 32'd3, M_FIX);
    put(`OP_AND,  7'd24, 6'd24, TAG, 32'd17, TAG, 32'd18, M_FIX);
    // With robid 16 these fill every entry
    put(`OP_ADD,  7'd30, 6'd1, TAG, NO_TAG, RDY, 32'd0, M_RND);
    put(`OP_SUB,  7'd31, 6'd2, TAG, NO_TAG, RDY, 32'd0, M_RND);
    put(`OP_MUL,  7'd32, 6'd3, TAG, NO_TAG, RDY, 32'd0, M_RND);
    put(`OP_XOR,  7'd33, 6'd4, TAG, NO_TAG, RDY, 32'd0, M_RND);
    put(`OP_MULH, 7'd34, 6'd5, TAG, NO_TAG, RDY, 32'd0, M_RND);
    put(`OP_OR,   7'd35, 6'd6, TAG, NO_TAG, RDY, 32'd0, M_RND);
    put(`OP_SLT,  7'd36, 6'd7, TAG, NO_TAG, RDY, 32'd0, M_RND);
    put(`OP_ADD,  7'd40, 6'd1, RDY, 32'h1234, RDY, 32'h10, M_BLK);
    // Cluster keeps working after the flush
    put(`OP_ADD,  7'd41, 6'd2, RDY, 32'd0, RDY, 32'd0, M_RND);
    put(`OP_MUL,  7'd42, 6'd3, TAG, 32'd41, RDY, 32'd7, M_FIX);
  endtask

  // ROB view of one operand: value known, value still coming, or never coming
  task automatic operand(input logic r, input exu_pkg::word_t v, input logic rnd,
                         output logic rdy, output exu_pkg::word_t drv,
                         output exu_pkg::word_t val, output logic stuck);
    exu_pkg::robid_t t;
    t = v[6:0];
    stuck = 1'b0;
    if (r) begin
      val = rnd ? $random(seed) : v;
      rdy = 1'b1;
      drv = val;
    end else if (known[t] && will_ret[t] && !exp_rd[t][5]) begin
      val = exp_val[t];
      rdy = seen[t];
      drv = seen[t] ? val : {25'b0, t};
    end else begin
      val = '0;
      rdy = 1'b0;
      drv = {25'b0, t};
      stuck = 1'b1;
    end
  endtask

  task automatic wait_all_results();
    while (seen_count != expect_count) begin
      @(posedge clk);
      #2;
    end
  endtask

  // Four-phase dispatch of one row, entered and left 2 ns after a rising edge
  task automatic apply_row(input int i);
    row_t           rw;
    exu_pkg::word_t a;
    exu_pkg::word_t b;
    exu_pkg::word_t d1;
    exu_pkg::word_t d2;
    logic           q1;
    logic           q2;
    logic           s1;
    logic           s2;
    rw = rows[i];
    operand(rw.r1, rw.v1, rw.mode == M_RND, q1, d1, a, s1);
    operand(rw.r2, rw.v2, rw.mode == M_RND, q2, d2, b, s2);
    known[rw.robid]    = 1'b1;
    exp_rd[rw.robid]   = rw.rd;
    exp_val[rw.robid]  = ref_alu(rw.op, a, b);
    will_ret[rw.robid] = !(s1 || s2) && rw.mode != M_BLK;
    if (will_ret[rw.robid]) expect_count++;
    if (rw.mode == M_BLK) wait_all_results();
    in_op       = rw.op;
    in_robid    = rw.robid;
    in_rd       = rw.rd;
    in_op1ready = q1;
    in_op1      = d1;
    in_op2ready = q2;
    in_op2      = d2;
    in_req      = 1'b1;
    if (rw.mode == M_BLK) begin
      repeat (BLOCK_CYCLES) begin
        @(posedge clk);
        #2;
        compare(in_ack, 1'b0, "in_ack with station full");
      end
      flush = 1'b1;
      @(posedge clk);
      #2;
      flush = 1'b0;
    end
    do begin
      @(posedge clk);
      #2;
    end while (!in_ack);
    in_req = 1'b0;
    do begin
      @(posedge clk);
      #2;
    end while (in_ack);
  endtask

  // Reset checks, then scoreboard on every broadcast
  initial begin
    forever begin
      @(posedge clk);
      #1;
      if (!rst_n) begin
        compare(in_ack, 1'b0, "in_ack during reset");
        compare(out_valid, 1'b0, "out_valid during reset");
      end else if (out_valid) begin
        compare(will_ret[out_robid], 1'b1, "robid allowed on output");
        compare(seen[out_robid], 1'b0, "robid returned only once");
        compare(out_rd, exp_rd[out_robid], "rd for robid");
        compare(out_result, exp_val[out_robid], "result for robid");
        seen[out_robid] = 1'b1;
        seen_count++;
      end
    end
  end

  initial begin
    #((NROWS * 40 + RST_CYCLES) * CLK_NS);
    $display("Watchdog expired before the tests completed");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    seed         = 32'he40d_62b5;
    errors       = 0;
    nrows        = 0;
    expect_count = 0;
    seen_count   = 0;
    flush        = 1'b0;
    in_req       = 1'b0;
    in_op        = '0;
    in_robid     = '0;
    in_rd        = '0;
    in_op1ready  = 1'b0;
    in_op1       = '0;
    in_op2ready  = 1'b0;
    in_op2       = '0;
    for (int k = 0; k < 128; k++) begin
      exp_val[k]  = '0;
      exp_rd[k]   = '0;
      known[k]    = 1'b0;
      will_ret[k] = 1'b0;
      seen[k]     = 1'b0;
    end
    build_table();
    wait (rst_n === 1'b1);
    for (int i = 0; i < nrows; i++) begin
      apply_row(i);
    end
    wait_all_results();
    // Flushed robids must stay off the output
    repeat (BLOCK_CYCLES) @(posedge clk);
    prop_fails = i_exu_top.i_exers.i_rs_props.fail_count
               + i_exu_top.i_dispatch_decode.i_dec_props.fail_count;
    if (errors == 0 && prop_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
